// ==== hw/muldiv_pkg.sv ====
`default_nettype none

package muldiv_pkg;

    // operand and result width.
    localparam int xlen = 32;

    // one divider iteration per quotient bit.
    localparam int div_steps = xlen;

    localparam int op_w = 3;

    // funct3 encodings of the RV32M group.
    localparam logic [op_w-1:0] op_mul    = 3'd0;
    localparam logic [op_w-1:0] op_mulh   = 3'd1;
    localparam logic [op_w-1:0] op_mulhsu = 3'd2;
    localparam logic [op_w-1:0] op_mulhu  = 3'd3;
    localparam logic [op_w-1:0] op_div    = 3'd4;
    localparam logic [op_w-1:0] op_divu   = 3'd5;
    localparam logic [op_w-1:0] op_rem    = 3'd6;
    localparam logic [op_w-1:0] op_remu   = 3'd7;

endpackage

`default_nettype wire

// ==== hw/operand_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface operand_if;
    import muldiv_pkg::*;

    logic            go;
    logic [op_w-1:0] op;
    logic [xlen-1:0] mag_a;
    logic [xlen-1:0] mag_b;
    logic            neg_prod;
    logic            neg_quot;
    logic            neg_rem;
    logic            b_zero;

    // all fields stay stable from go until the next accepted start.
    modport prep (
        output go, op, mag_a, mag_b, neg_prod, neg_quot, neg_rem, b_zero
    );

    modport unit (
        input go, op, mag_a, mag_b, neg_prod, neg_quot, neg_rem, b_zero
    );

endinterface

`default_nettype wire

// ==== hw/unit_result_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface unit_result_if;
    import muldiv_pkg::*;

    // unsigned product, valid with mul_done.
    logic [2*xlen-1:0] product;
    logic              mul_done;

    // quotient and remainder magnitudes, valid with div_done.
    logic [xlen-1:0]   quotient;
    logic [xlen-1:0]   remainder;
    logic              div_done;

    modport unit (
        output product, mul_done, quotient, remainder, div_done
    );

    modport fix (
        input product, mul_done, quotient, remainder, div_done
    );

endinterface

`default_nettype wire

// ==== hw/operand_prep.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_prep (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start,
    input  wire [muldiv_pkg::op_w-1:0]  op,
    input  wire [muldiv_pkg::xlen-1:0]  a,
    input  wire [muldiv_pkg::xlen-1:0]  b,
    input  wire                         done,
    output logic                        busy,
    operand_if.prep                     opnd
);
    import muldiv_pkg::*;

    logic accept;
    logic sign_a;
    logic sign_b;
    logic signed_div;

    assign accept = start && !busy;

    // a is treated as signed for mul, mulh, mulhsu and signed division.
    assign signed_div = (op == op_div) || (op == op_rem);
    assign sign_a = a[xlen-1] && ((op == op_mul) || (op == op_mulh) ||
                                  (op == op_mulhsu) || signed_div);
    assign sign_b = b[xlen-1] && ((op == op_mul) || (op == op_mulh) || signed_div);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            opnd.go <= 1'b0;
        end else begin
            opnd.go <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opnd.op       <= op;
            opnd.mag_a    <= sign_a ? -a : a;
            opnd.mag_b    <= sign_b ? -b : b;
            opnd.neg_prod <= sign_a ^ sign_b;
            opnd.neg_quot <= signed_div && (a[xlen-1] ^ b[xlen-1]);
            // remainder follows the dividend's sign.
            opnd.neg_rem  <= signed_div && a[xlen-1];
            opnd.b_zero   <= (b == '0);
        end
    end

    // done only comes back for an operation in flight.
    done_only_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> busy
    );

endmodule

`default_nettype wire

// ==== hw/mul_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_unit (
    input  wire          clk,
    input  wire          rst_n,
    operand_if.unit      opnd,
    unit_result_if.unit  res
);
    import muldiv_pkg::*;

    logic [2*xlen-1:0] raw;
    logic              raw_valid;

    // first stage holds the raw product.
    always_ff @(posedge clk) begin
        if (opnd.go) begin
            raw <= opnd.mag_a * opnd.mag_b;
        end
    end

    // second stage, product holds until the next operation.
    always_ff @(posedge clk) begin
        if (raw_valid) begin
            res.product <= raw;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            raw_valid    <= 1'b0;
            res.mul_done <= 1'b0;
        end else begin
            raw_valid    <= opnd.go;
            res.mul_done <= raw_valid;
        end
    end

endmodule

`default_nettype wire

// ==== hw/div_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module div_unit (
    input  wire          clk,
    input  wire          rst_n,
    operand_if.unit      opnd,
    unit_result_if.unit  res
);
    import muldiv_pkg::*;

    logic [2*xlen-1:0]            shifter;
    logic [xlen-1:0]              quot;
    logic [$clog2(div_steps)-1:0] step;
    logic                         running;
    logic                         load;
    logic [xlen:0]                cand;
    logic [xlen:0]                diff;
    logic                         ge;

    // only division ops start the iteration.
    assign load = opnd.go && (opnd.op inside {op_div, op_divu, op_rem, op_remu});

    // partial remainder with the next dividend bit, one bit wider than b.
    assign cand = shifter[2*xlen-1:xlen-1];
    assign ge   = cand >= {1'b0, opnd.mag_b};
    assign diff = cand - {1'b0, opnd.mag_b};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running      <= 1'b0;
            step         <= '0;
            res.div_done <= 1'b0;
        end else begin
            res.div_done <= 1'b0;
            if (load) begin
                running <= 1'b1;
                step    <= '0;
            end else if (running) begin
                step <= step + 1'b1;
                if (int'(step) == div_steps - 1) begin
                    running      <= 1'b0;
                    res.div_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shifter <= {{xlen{1'b0}}, opnd.mag_a};
            quot    <= '0;
        end else if (running) begin
            quot <= {quot[xlen-2:0], ge};
            if (ge) begin
                shifter <= {diff[xlen-1:0], shifter[xlen-2:0], 1'b0};
            end else begin
                shifter <= {shifter[2*xlen-2:0], 1'b0};
            end
        end
    end

    // with b zero every step subtracts nothing, so quot ends all ones.
    assign res.quotient  = quot;
    assign res.remainder = shifter[2*xlen-1:xlen];

    no_go_while_running: assert property (
        @(posedge clk) disable iff (!rst_n)
        opnd.go |-> !running
    );

endmodule

`default_nettype wire

// ==== hw/result_fixup.sv ====
`timescale 1ns/10ps
`default_nettype none

module result_fixup (
    input  wire                         clk,
    input  wire                         rst_n,
    operand_if.unit                     opnd,
    unit_result_if.fix                  res,
    output logic [muldiv_pkg::xlen-1:0] result,
    output logic                        done
);
    import muldiv_pkg::*;

    logic              is_div;
    logic              take;
    logic [2*xlen-1:0] prod_fix;
    logic [xlen-1:0]   quot_fix;
    logic [xlen-1:0]   rem_fix;
    logic [xlen-1:0]   sel;

    assign is_div = opnd.op inside {op_div, op_divu, op_rem, op_remu};

    // mul_done also fires for division ops and is dropped here.
    assign take = is_div ? res.div_done : res.mul_done;

    assign prod_fix = opnd.neg_prod ? -res.product : res.product;
    // divide by zero keeps the all-ones quotient.
    assign quot_fix = (opnd.neg_quot && !opnd.b_zero) ? -res.quotient : res.quotient;
    assign rem_fix  = opnd.neg_rem ? -res.remainder : res.remainder;

    always_comb begin
        case (opnd.op)
            op_mul:                       sel = prod_fix[xlen-1:0];
            op_mulh, op_mulhsu, op_mulhu: sel = prod_fix[2*xlen-1:xlen];
            op_div, op_divu:              sel = quot_fix;
            default:                      sel = rem_fix;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= take;
            if (take) begin
                result <= sel;
            end
        end
    end

    // one result per operation.
    single_cycle_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    );

endmodule

`default_nettype wire

// ==== hw/muldiv_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module muldiv_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start,
    input  wire [muldiv_pkg::op_w-1:0]  op,
    input  wire [muldiv_pkg::xlen-1:0]  a,
    input  wire [muldiv_pkg::xlen-1:0]  b,
    output logic [muldiv_pkg::xlen-1:0] result,
    output logic                        done,
    output logic                        busy
);

    operand_if     opnd_bus ();
    unit_result_if res_bus ();

    // done closes the loop back to the input side.
    operand_prep u_prep (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .op    (op),
        .a     (a),
        .b     (b),
        .done  (done),
        .busy  (busy),
        .opnd  (opnd_bus)
    );

    mul_unit u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .opnd  (opnd_bus),
        .res   (res_bus)
    );

    div_unit u_div (
        .clk   (clk),
        .rst_n (rst_n),
        .opnd  (opnd_bus),
        .res   (res_bus)
    );

    result_fixup u_fix (
        .clk    (clk),
        .rst_n  (rst_n),
        .opnd   (opnd_bus),
        .res    (res_bus),
        .result (result),
        .done   (done)
    );

endmodule

`default_nettype wire

// ==== bench/muldiv_ref.svh ====
`ifndef muldiv_ref_svh
`define muldiv_ref_svh

// expected rv32m result from native 64-bit and 32-bit arithmetic.
function automatic logic [xlen-1:0] ref_result(
    input logic [op_w-1:0] o,
    input logic [xlen-1:0] va,
    input logic [xlen-1:0] vb
);
    logic signed [2*xlen-1:0] sa;
    logic signed [2*xlen-1:0] sb;
    logic [2*xlen-1:0]        ua;
    logic [2*xlen-1:0]        ub;
    logic [2*xlen-1:0]        prod;
    logic signed [xlen-1:0]   sqa;
    logic signed [xlen-1:0]   sqb;
    logic [xlen-1:0]          quot;
    logic [xlen-1:0]          rem;
    logic                     signed_op;
    sa = {{xlen{va[xlen-1]}}, va};
    sb = {{xlen{vb[xlen-1]}}, vb};
    ua = {{xlen{1'b0}}, va};
    ub = {{xlen{1'b0}}, vb};
    sqa = va;
    sqb = vb;
    signed_op = (o == op_div) || (o == op_rem);
    case (o)
        op_mulh:   prod = sa * sb;
        op_mulhsu: prod = sa * $signed(ub);
        default:   prod = ua * ub;
    endcase
    // division by zero and signed overflow follow the isa rules.
    if (vb == '0) begin
        quot = '1;
        rem  = va;
    end else if (signed_op && va == 32'h8000_0000 && vb == 32'hffff_ffff) begin
        quot = va;
        rem  = '0;
    end else if (signed_op) begin
        quot = sqa / sqb;
        rem  = sqa % sqb;
    end else begin
        quot = va / vb;
        rem  = va % vb;
    end
    case (o)
        op_mul:                       return prod[xlen-1:0];
        op_mulh, op_mulhsu, op_mulhu: return prod[2*xlen-1:xlen];
        op_div, op_divu:              return quot;
        default:                      return rem;
    endcase
endfunction

`endif

// ==== bench/muldiv_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module muldiv_tb;
    import muldiv_pkg::*;

    `include "muldiv_ref.svh"

    localparam int clk_period = 4;
    localparam int num_ops    = 156;
    localparam int timeout_ns = num_ops * 40 * clk_period + 200;

    logic            clk;
    logic            rst_n;
    logic            start;
    logic [op_w-1:0] op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] result;
    logic            done;
    logic            busy;

    logic [15:0]     lfsr = 16'd23033;
    int              cyc = 0;
    int              issued = 0;
    int              checked = 0;
    int              mismatches = 0;
    int              protocol_errors = 0;
    int              setup_errors = 0;
    logic            idle_check = 1'b0;
    logic [xlen-1:0] exp_result;
    int              exp_lat;
    int              start_cyc;
    logic [op_w-1:0] cur_op;
    logic [xlen-1:0] cur_a;
    logic [xlen-1:0] cur_b;
    logic [xlen-1:0] x;
    logic [xlen-1:0] y;
    logic [xlen-1:0] corner_a [4] = '{32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 32'hffff_ffff};
    logic [xlen-1:0] corner_b [4] = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h0000_0001};

    muldiv_top dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .result (result),
        .done   (done),
        .busy   (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // x^16 + x^14 + x^13 + x^11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_word(output logic [xlen-1:0] w);
        for (int i = 0; i < xlen; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[xlen-2:0], lfsr[0]};
        end
    endtask

    task automatic launch(input logic [op_w-1:0] o, input logic [xlen-1:0] va, vb);
        @(posedge clk);
        #1;
        start = 1'b1;
        op = o;
        a = va;
        b = vb;
        cur_op = o;
        cur_a = va;
        cur_b = vb;
        exp_result = ref_result(o, va, vb);
        exp_lat = (o >= op_div) ? 35 : 4;
        start_cyc = cyc;
        issued++;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic run_op(input logic [op_w-1:0] o, input logic [xlen-1:0] va, vb);
        launch(o, va, vb);
        wait (checked == issued);
    endtask

    // a second start of the other class lands while the first one runs.
    task automatic run_op_busy_start(input logic [op_w-1:0] o, input logic [xlen-1:0] va, vb,
                                     input int gap);
        launch(o, va, vb);
        repeat (gap) @(posedge clk);
        #1;
        start = 1'b1;
        op = o ^ 3'd4;
        a = vb;
        b = va;
        @(posedge clk);
        #1;
        start = 1'b0;
        wait (checked == issued);
        repeat (10) @(posedge clk);
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (idle_check && busy) begin
                    $display("ERROR: busy still high one cycle after done");
                    protocol_errors++;
                end
                idle_check = 1'b0;
                if (checked != issued && cyc > start_cyc && !busy) begin
                    $display("ERROR: busy low while an operation is in flight");
                    protocol_errors++;
                end
                if (done && checked == issued) begin
                    $display("ERROR: done pulsed with no operation in flight");
                    protocol_errors++;
                end else if (done) begin
                    if (cyc - start_cyc != exp_lat) begin
                        $display("MISMATCH done latency: expected %h got %h",
                                 exp_lat, cyc - start_cyc);
                        mismatches++;
                    end
                    if (result !== exp_result) begin
                        $display("MISMATCH result: op %h a %h b %h expected %h got %h",
                                 cur_op, cur_a, cur_b, exp_result, result);
                        mismatches++;
                    end
                    checked++;
                    idle_check = 1'b1;
                end
            end
        end
    end

    initial begin
        #(timeout_ns);
        $display("ERROR: timeout after %0d ns, done never arrived", timeout_ns);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        op = '0;
        a = '0;
        b = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (done || busy || result !== '0) begin
            $display("ERROR: outputs not cleared by reset");
            setup_errors++;
        end

        for (int i = 0; i < 40; i++) begin
            rand_word(x);
            rand_word(y);
            run_op(op_mul, x, y);
        end
        run_op(op_mul, 32'h0, 32'h0);
        run_op(op_mul, 32'h0, y);
        run_op(op_mul, 32'h1, y);
        run_op(op_mul, 32'hffff_ffff, y);
        run_op(op_mul, x, 32'hffff_ffff);
        run_op(op_mul, 32'hffff_ffff, 32'hffff_ffff);

        // the last four high-word pairs are fixed extremes.
        for (int i = 0; i < 16; i++) begin
            rand_word(x);
            rand_word(y);
            if (i >= 12) begin
                x = corner_a[i-12];
                y = corner_b[i-12];
            end
            for (int k = int'(op_mulh); k <= int'(op_mulhu); k++) begin
                run_op(k[op_w-1:0], x, y);
            end
        end

        for (int i = 0; i < 12; i++) begin
            rand_word(x);
            rand_word(y);
            // small divisors give long quotients.
            if (i % 2 == 1) begin
                y = y >> 20;
            end
            if (i % 4 == 3) begin
                y = -y;
            end
            for (int k = int'(op_div); k <= int'(op_remu); k++) begin
                run_op(k[op_w-1:0], x, y);
            end
        end

        rand_word(x);
        for (int k = int'(op_div); k <= int'(op_remu); k++) begin
            run_op(k[op_w-1:0], {1'b0, x[xlen-2:0]}, 32'h0);
            run_op(k[op_w-1:0], {1'b1, x[xlen-2:0]}, 32'h0);
            run_op(k[op_w-1:0], 32'h8000_0000, 32'hffff_ffff);
        end

        run_op_busy_start(op_mulhu, x, y, 2);
        run_op_busy_start(op_rem, y, x, 10);

        repeat (20) @(posedge clk);
        $display("summary: %0d mismatches, %0d protocol errors, %0d other errors, %0d ops",
                 mismatches, protocol_errors, setup_errors, checked);
        if (mismatches + protocol_errors + setup_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+bench
hw/muldiv_pkg.sv
hw/operand_if.sv
hw/unit_result_if.sv
hw/operand_prep.sv
hw/mul_unit.sv
hw/div_unit.sv
hw/result_fixup.sv
hw/muldiv_top.sv
bench/muldiv_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f files.f --top-module muldiv_tb -o muldiv_sim

./obj_dir/muldiv_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0
